// ==== rtl/uart_rx_pkg.sv ====
/*
  UART receiver package
  Frame constants, bit counter opcodes and the controller output bundle
*/
package uart_rx_pkg;

  // Frame format
  localparam int DATA_BITS     = 8;                    // Data bits per frame
  localparam int FRAME_BITS    = DATA_BITS + 1;        // Start bit is sampled too
  localparam int CLKS_PER_TICK = 4;                    // Quarter-bit tick, 16 clocks per bit

  // Bit counter must reach DATA_BITS
  localparam int CNT_BITS      = $clog2(DATA_BITS + 1);

  // Bit counter opcode
  typedef enum logic [1:0] {
    CNT_CLEAR = 2'b00,                                 // Back to zero
    CNT_HOLD  = 2'b01,                                 // Keep value
    CNT_INC   = 2'b10                                  // Count one bit
  } cnt_op_t;

  // Controller outputs, 4 bits
  typedef struct packed {
    cnt_op_t cnt_op;                                   // To bit counter
    logic    shift_en;                                 // Sample strobe to shift register
    logic    eor;                                      // Idle, end of reception
  } rx_ctrl_t;

endpackage

// ==== rtl/baud_tick_gen.sv ====
/*
  Baud tick generator
  Divides the system clock into quarter-bit ticks, phase restarts while idle
*/
`timescale 1ns/1ps

module baud_tick_gen #(
  parameter int DIVIDE = uart_rx_pkg::CLKS_PER_TICK
) (
  input  logic clk_i,
  input  logic rst_i,
  input  logic idle_i,
  output logic tick_o
);

  localparam int CW = (DIVIDE > 1) ? $clog2(DIVIDE) : 1;

  logic [CW-1:0] div_q;
  logic          wrap;

  assign wrap = (div_q == CW'(DIVIDE - 1));          // Last clock of the tick period

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      div_q <= '0;
    end else if (idle_i || wrap) begin
      div_q <= '0;                                   // Align phase to the start edge
    end else begin
      div_q <= div_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      tick_o <= 1'b0;
    end else begin
      tick_o <= wrap && !idle_i;                     // One clock pulse after the wrap
    end
  end

endmodule

// ==== rtl/rx_ctrl_fsm.sv ====
/*
  UART receive controller
  Walks start, data and stop bits by counting quarter-bit ticks and
  drives the bit counter opcode, the sample strobe and the idle level
*/
`timescale 1ns/1ps

module rx_ctrl_fsm (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  rx_i,
  input  logic                  tick_i,
  input  logic                  last_bit_i,
  output uart_rx_pkg::rx_ctrl_t ctrl_o
);

  typedef enum logic [3:0] {
    S_IDLE   = 4'd0,                                 // Wait for start edge
    S_HALF1  = 4'd1,                                 // First tick toward bit center
    S_HALF2  = 4'd2,                                 // Second tick toward bit center
    S_SAMPLE = 4'd3,                                 // Shift in the line
    S_NEXT1  = 4'd4,                                 // First tick toward bit edge
    S_NEXT2  = 4'd5,                                 // Second tick, branch on last bit
    S_INC    = 4'd6,                                 // Count the sampled bit
    S_STOP1  = 4'd7,                                 // First tick into stop bit
    S_STOP2  = 4'd8                                  // Second tick, back to idle
  } state_t;

  state_t state_q;
  state_t state_d;

  // Next state and output decode
  always_comb begin
    state_d         = state_q;
    ctrl_o.cnt_op   = uart_rx_pkg::CNT_HOLD;
    ctrl_o.shift_en = 1'b0;
    ctrl_o.eor      = 1'b0;

    case (state_q)
      S_IDLE: begin
        ctrl_o.cnt_op = uart_rx_pkg::CNT_CLEAR;
        ctrl_o.eor    = 1'b1;
        if (!rx_i) begin
          state_d = S_HALF1;                         // Line went low
        end
      end
      S_HALF1: begin
        if (tick_i) begin
          state_d = S_HALF2;
        end
      end
      S_HALF2: begin
        if (tick_i) begin
          state_d = S_SAMPLE;
        end
      end
      S_SAMPLE: begin
        ctrl_o.shift_en = 1'b1;
        state_d         = S_NEXT1;
      end
      S_NEXT1: begin
        if (tick_i) begin
          state_d = S_NEXT2;
        end
      end
      S_NEXT2: begin
        if (tick_i) begin
          if (last_bit_i) begin
            state_d = S_STOP1;                       // All data bits taken
          end else begin
            state_d = S_INC;
          end
        end
      end
      S_INC: begin
        ctrl_o.cnt_op = uart_rx_pkg::CNT_INC;
        state_d       = S_HALF1;
      end
      S_STOP1: begin
        if (tick_i) begin
          state_d = S_STOP2;
        end
      end
      S_STOP2: begin
        if (tick_i) begin
          state_d = S_IDLE;                          // Middle of stop bit
        end
      end
      default: begin
        state_d = S_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= S_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// ==== rtl/rx_bit_counter.sv ====
/*
  Receive bit counter
  Clears, holds or increments on the controller opcode, flags the last data bit
*/
`timescale 1ns/1ps

module rx_bit_counter (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  uart_rx_pkg::cnt_op_t op_i,
  output logic                 last_bit_o
);

  logic [uart_rx_pkg::CNT_BITS-1:0] count_q;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      count_q <= '0;
    end else begin
      case (op_i)
        uart_rx_pkg::CNT_CLEAR: count_q <= '0;
        uart_rx_pkg::CNT_INC:   count_q <= count_q + 1'b1;
        uart_rx_pkg::CNT_HOLD:  count_q <= count_q;
        default:                count_q <= count_q;    // Unused code holds
      endcase
    end
  end

  // Start bit plus DATA_BITS samples done
  assign last_bit_o =
    (count_q == uart_rx_pkg::CNT_BITS'(uart_rx_pkg::DATA_BITS));

endmodule

// ==== rtl/rx_shift_reg.sv ====
/*
  Receive shift register
  Shifts the line in from the top on each sample strobe, drops the start bit
*/
`timescale 1ns/1ps

module rx_shift_reg (
  input  logic                             clk_i,
  input  logic                             rst_i,
  input  logic                             rx_i,
  input  logic                             shift_en_i,
  output logic [uart_rx_pkg::DATA_BITS-1:0] data_o
);

  logic [uart_rx_pkg::FRAME_BITS-1:0] sr_q;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      sr_q <= '0;
    end else if (shift_en_i) begin
      sr_q <= {rx_i, sr_q[uart_rx_pkg::FRAME_BITS-1:1]}; // LSB first on the line
    end
  end

  // Start bit ends up in bit zero
  assign data_o = sr_q[uart_rx_pkg::FRAME_BITS-1:1];

endmodule

// ==== rtl/uart_rx.sv ====
/*
  UART receiver top level
  Tick generator, receive controller, bit counter and shift register
*/
`timescale 1ns/1ps

module uart_rx (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  logic                              rx_i,
  output logic [uart_rx_pkg::DATA_BITS-1:0] data_o,
  output logic                              eor_o
);

  uart_rx_pkg::rx_ctrl_t ctrl;                       // Controller bundle
  logic                  tick;                       // Quarter-bit strobe
  logic                  last_bit;                   // Count reached DATA_BITS

  baud_tick_gen #(
    .DIVIDE (uart_rx_pkg::CLKS_PER_TICK)
  ) u_tick (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .idle_i (ctrl.eor),                              // Divider held while idle
    .tick_o (tick)
  );

  rx_ctrl_fsm u_fsm (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .rx_i       (rx_i),
    .tick_i     (tick),
    .last_bit_i (last_bit),
    .ctrl_o     (ctrl)
  );

  rx_bit_counter u_cnt (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .op_i       (ctrl.cnt_op),
    .last_bit_o (last_bit)
  );

  rx_shift_reg u_sipo (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .rx_i       (rx_i),
    .shift_en_i (ctrl.shift_en),
    .data_o     (data_o)
  );

  assign eor_o = ctrl.eor;                           // High while idle

endmodule

// ==== verification/tb_clock_gen.sv ====
/*
  Testbench clock and reset generator
  Free running clock, reset held high for a fixed number of cycles
*/
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD       = 4,
  parameter int RESET_CYCLES = 5
) (
  output logic clk_o,
  output logic rst_o
);

  initial clk_o = 1'b0;
  always #(PERIOD / 2) clk_o = ~clk_o;

  initial begin
    rst_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1 rst_o = 1'b0;                                 // Release just after the edge
  end

endmodule

// ==== verification/tb_uart_rx.sv ====
/*
  UART receiver testbench
  Drives serial frames from a stimulus table and checks each received byte
  when eor_o rises, plus idle hold and mid-frame reset cases
*/
`timescale 1ns/1ps

module tb_uart_rx;

  localparam int CLK_PERIOD  = 4;
  localparam int DRIVE_DLY   = 1;
  localparam int BIT_CLKS    = 4 * uart_rx_pkg::CLKS_PER_TICK;
  localparam int FRAME_CLKS  = 10 * BIT_CLKS;        // Start, data and stop
  localparam int IDLE_CLKS   = 200;
  localparam int NUM_ROWS    = 17;
  localparam int NAME_LEN    = 12;
  localparam int WATCHDOG_NS = 2 * ((NUM_ROWS + 2) * FRAME_CLKS + IDLE_CLKS) * CLK_PERIOD;

  typedef struct packed {
    logic [8*NAME_LEN-1:0]              name;
    logic [uart_rx_pkg::DATA_BITS-1:0] data;
    logic                              half_stop;    // Next frame starts mid stop bit
  } row_t;

  logic                              clk;
  logic                              rst_por;
  logic                              rst_extra;
  logic                              rst;
  logic                              rx;
  logic [uart_rx_pkg::DATA_BITS-1:0] data;
  logic                              eor;

  row_t stim_table [NUM_ROWS];
  int   pass_cnt;
  int   fail_cnt;

  assign rst = rst_por | rst_extra;                  // Power-on or mid-frame reset

  tb_clock_gen #(
    .PERIOD       (CLK_PERIOD),
    .RESET_CYCLES (5)
  ) u_clk (
    .clk_o (clk),
    .rst_o (rst_por)
  );

  uart_rx u_dut (
    .clk_i  (clk),
    .rst_i  (rst),
    .rx_i   (rx),
    .data_o (data),
    .eor_o  (eor)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic row_t make_row(input logic [8*NAME_LEN-1:0] name,
                                    input logic [7:0] value, input logic half);
    row_t row;
    row.name      = name;
    row.data      = value;
    row.half_stop = half;
    return row;
  endfunction

  task automatic build_table();
    logic [31:0] seed;
    seed = 32'd83;
    stim_table[0] = make_row("byte_00", 8'h00, 1'b0);
    stim_table[1] = make_row("byte_ff", 8'hFF, 1'b0);
    stim_table[2] = make_row("byte_a5", 8'hA5, 1'b0);
    stim_table[3] = make_row("byte_5a", 8'h5A, 1'b0);
    stim_table[4] = make_row("byte_01", 8'h01, 1'b0);
    stim_table[5] = make_row("byte_80", 8'h80, 1'b0);
    stim_table[6] = make_row("b2b_c3", 8'hC3, 1'b1);   // Half stop bits
    stim_table[7] = make_row("b2b_3c", 8'h3C, 1'b1);
    stim_table[8] = make_row("b2b_96", 8'h96, 1'b0);
    for (int i = 0; i < 8; i++) begin
      seed = lcg_next(seed);
      stim_table[9 + i] = make_row({"lcg_", 8'(8'd48 + i)}, seed[23:16], 1'b0);
    end
  endtask

  // One line bit lasting n clocks
  task automatic drive_bit(input logic value, input int n);
    @(posedge clk);
    #DRIVE_DLY rx = value;
    repeat (n - 1) @(posedge clk);
  endtask

  task automatic drive_frame(input logic [7:0] value, input logic half);
    drive_bit(1'b0, BIT_CLKS);                       // Start bit
    for (int i = 0; i < uart_rx_pkg::DATA_BITS; i++) begin
      drive_bit(value[i], BIT_CLKS);                 // LSB first
    end
    drive_bit(1'b1, half ? BIT_CLKS / 2 : BIT_CLKS);
  endtask

  task automatic compare_byte(input logic [8*NAME_LEN-1:0] name,
                              input logic [7:0] expected, input logic [7:0] actual);
    if (actual !== expected) begin
      $display("error %0s expected %h actual %h", name, expected, actual);
      fail_cnt++;
    end else begin
      $display("pass %0s data %h", name, actual);
      pass_cnt++;
    end
  endtask

  task automatic flag_failure(input logic [8*NAME_LEN-1:0] name, input string what);
    $display("fail %0s: %0s", name, what);
    fail_cnt++;
  endtask

  // Wait for the frame to start, then for eor_o to rise
  task automatic check_frame(input row_t row);
    int waited;
    waited = 0;
    @(negedge clk);
    while (eor === 1'b1 && waited < 2 * FRAME_CLKS) begin
      @(negedge clk);
      waited++;
    end
    if (eor === 1'b1) begin
      flag_failure(row.name, "receiver never left idle for the frame");
    end else begin
      waited = 0;
      while (eor !== 1'b1 && waited < 2 * FRAME_CLKS) begin
        @(negedge clk);
        waited++;
      end
      if (eor !== 1'b1) begin
        flag_failure(row.name, "eor_o never rose after the frame");
      end else begin
        compare_byte(row.name, row.data, data);
      end
    end
  endtask

  // Data and eor_o stay put while the line idles high
  task automatic hold_idle_check(input logic [7:0] last);
    logic       eor_dropped;
    logic [7:0] seen;
    eor_dropped = 1'b0;
    seen        = last;
    repeat (IDLE_CLKS) begin
      @(negedge clk);
      if (eor !== 1'b1) eor_dropped = 1'b1;
      if (data !== last) seen = data;
    end
    if (eor_dropped) begin
      flag_failure("idle_hold", "eor_o dropped while the line stayed idle");
    end else begin
      compare_byte("idle_hold", last, seen);
    end
  endtask

  task automatic reset_mid_frame();
    drive_bit(1'b0, BIT_CLKS);
    drive_bit(1'b0, BIT_CLKS);
    drive_bit(1'b1, BIT_CLKS);
    drive_bit(1'b1, BIT_CLKS);                       // Start bit and three data bits
    @(posedge clk);
    #DRIVE_DLY;
    rst_extra = 1'b1;
    rx        = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    if (eor !== 1'b1) begin
      flag_failure("mid_reset", "eor_o not high after the mid-frame reset");
    end else begin
      compare_byte("mid_reset", 8'h00, data);
    end
    @(posedge clk);
    #DRIVE_DLY rst_extra = 1'b0;
    fork
      drive_frame(8'hC6, 1'b0);
      check_frame(make_row("after_reset", 8'hC6, 1'b0));
    join
  endtask

  initial begin
    rx        = 1'b1;
    rst_extra = 1'b0;
    pass_cnt  = 0;
    fail_cnt  = 0;
    build_table();
    wait (rst_por == 1'b0);
    @(negedge clk);
    if (eor !== 1'b1) begin
      flag_failure("reset_state", "eor_o not high after reset");
    end else begin
      compare_byte("reset_state", 8'h00, data);
    end
    repeat (4) @(posedge clk);
    fork
      begin
        for (int i = 0; i < NUM_ROWS; i++) begin
          drive_frame(stim_table[i].data, stim_table[i].half_stop);
        end
      end
      begin
        for (int j = 0; j < NUM_ROWS; j++) begin
          check_frame(stim_table[j]);
        end
      end
    join
    hold_idle_check(stim_table[NUM_ROWS-1].data);
    reset_mid_frame();
    $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Bound on the whole run
  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before all tests finished");
    $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== vlog.f ====
rtl/uart_rx_pkg.sv
rtl/baud_tick_gen.sv
rtl/rx_ctrl_fsm.sv
rtl/rx_bit_counter.sv
rtl/rx_shift_reg.sv
rtl/uart_rx.sv
verification/tb_clock_gen.sv
verification/tb_uart_rx.sv
